// File: verification/lanzones_golden.txt
// per test: program length then its words, data pair count then address/word pairs,
// store count then expected address/data pairs, then expected fetch count; 0 ends the list
// test 1: halt, load-enable, LUI then SW
00000003 123450B7 04102023 0000007F
00000000
00000001 00000040 12345000
00000003
// test 2: ADD wraps, SUB, unknown funct7 as ADD
00000009 800000B7 00108133 000011B7 40310233 023082B3 04202023 044020A3 04502123 0000007F
00000000
00000003 00000040 00000000 00000041 FFFFF000 00000042 80001000
00000009
// test 3: loads stored back, negative offset, LB as LW, unknown opcode
00000007 05002303 05102383 FE63AF23 00038403 0083A0A3 0000000F 0000007F
00000003 00000050 CAFEF00D 00000051 00000060 00000060 0BADBEEF
00000002 0000005E CAFEF00D 00000061 0BADBEEF
00000007
// test 4: x0 targeted by LUI and LW, all-ones halt
00000007 ABCDE037 05002003 000774B7 00900533 04002023 04A020A3 FFFFFFFF
00000001 00000050 11111111
00000002 00000040 00000000 00000041 00077000
00000007
// end of list
00000000

// File: tb.f
logic/isaPkg.sv
logic/memBusPkg.sv
logic/fetchSequencer.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/lanzonesCore.sv
verification/tbLanzones.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core regression with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=simLanzones
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module tbLanzones -Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

# the log decides
if grep -qx "Regression passed" "$logFile"; then
   exit 0
fi
exit 1

// File: verification/tbLanzones.sv
`timescale 1ns/1ps

module tbLanzones import isaPkg::*, memBusPkg::*; ();

   localparam int memDepth     = 256;
   localparam int goldenSize   = 512;
   localparam int maxTests     = 16;
   localparam int fetchTimeout = 20;
   localparam int runTimeout   = 2000;   // cycles per program
   localparam int quietCycles  = 20;

   logic     clk;
   logic     rstn;
   logic     LEn;
   logic     RVld  = 1'b0;
   memWord_t RData = '0;
   logic     RRdy;
   logic     RWEn;
   logic     Halt;
   memAddr_t RAddr;
   memWord_t RWData;

   memWord_t golden [goldenSize];
   memWord_t mem [memDepth];
   memAddr_t storeAddrQ [$];
   memWord_t storeDataQ [$];
   int       seed = 86;
   int       waitCnt;
   logic     memBusy;
   int       fetchCount;
   int       errors;
   int       testsRun;
   int       testsFailed;
   int       gPtr;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   lanzonesCore u_dut (
      .clk(clk), .rstn(rstn), .LEn(LEn), .RVld(RVld), .RData(RData),
      .RRdy(RRdy), .RWEn(RWEn), .Halt(Halt), .RAddr(RAddr), .RWData(RWData)
   );

   // memory model, answers each request after 1 to 4 cycles
   always @(posedge clk) begin
      if (!rstn) begin
         RVld    <= 1'b0;
         RData   <= '0;
         memBusy = 1'b0;
      end else if (RVld) begin
         RVld <= 1'b0;   // one-cycle strobe
      end else if (RRdy) begin
         if (!memBusy) begin
            memBusy = 1'b1;
            waitCnt = $random(seed) & 3;
         end
         if (waitCnt == 0) begin
            memBusy = 1'b0;
            RVld    <= 1'b1;
            if (RAddr >= memDepth) begin
               $display("%0t: request to address %0h lies outside the memory model",
                        $time, RAddr);
               errors++;
            end else if (RWEn) begin
               mem[RAddr[7:0]] = RWData;
               storeAddrQ.push_back(RAddr);
               storeDataQ.push_back(RWData);
            end else begin
               RData <= mem[RAddr[7:0]];
               // no branches, so a read at the next pc is a fetch
               if (RAddr == memAddr_t'(fetchCount)) fetchCount++;
            end
         end else begin
            waitCnt--;
         end
      end
   end

   task automatic checkStore(input memAddr_t expAddr, input memWord_t expData,
                             input memAddr_t actAddr, input memWord_t actData,
                             input string what);
      if (actAddr !== expAddr || actData !== expData) begin
         $display("MISMATCH %0t: %s expected addr %h data %h, got addr %h data %h",
                  $time, what, expAddr, expData, actAddr, actData);
         errors++;
      end
   endtask

   task automatic checkHalt(input logic expHalt, input int expCount,
                            input logic actHalt, input int actCount);
      if (actHalt !== expHalt || actCount != expCount) begin
         $display("MISMATCH %0t: expected Halt %b after %0d fetches, got Halt %b after %0d",
                  $time, expHalt, expCount, actHalt, actCount);
         errors++;
      end
   endtask

   task automatic runTest(input int testNum);
      int progLen;
      int dataLen;
      int storeLen;
      int storePtr;
      int expCount;
      int cycles;
      int errBefore;
      errBefore = errors;
      for (int i = 0; i < memDepth; i++) mem[i] = '0;
      progLen = int'(golden[gPtr]);
      gPtr++;
      for (int i = 0; i < progLen; i++) mem[i] = golden[gPtr + i];
      gPtr += progLen;
      dataLen = int'(golden[gPtr]);
      gPtr++;
      for (int i = 0; i < dataLen; i++) mem[golden[gPtr + 2*i][7:0]] = golden[gPtr + 2*i + 1];
      gPtr += 2 * dataLen;
      storeLen = int'(golden[gPtr]);
      storePtr = gPtr + 1;
      gPtr += 1 + 2 * storeLen;
      expCount = int'(golden[gPtr]);
      gPtr++;

      @(posedge clk);
      rstn <= 1'b0;
      LEn  <= 1'b0;
      fetchCount = 0;
      storeAddrQ.delete();
      storeDataQ.delete();
      repeat (5) @(posedge clk);
      rstn <= 1'b1;

      // halted until LEn, port quiet
      for (int i = 0; i < 3; i++) begin
         @(negedge clk);
         checkHalt(1'b1, 0, Halt, fetchCount);
         checkStore('0, '0, RAddr, RWData, "idle port");
         if (RRdy || RWEn) begin
            $display("MISMATCH %0t: RRdy or RWEn high before LEn", $time);
            errors++;
         end
      end

      @(posedge clk);
      LEn <= 1'b1;
      @(posedge clk);
      LEn <= 1'b0;
      cycles = 0;
      @(negedge clk);
      while (!RRdy && cycles < fetchTimeout) begin
         @(negedge clk);
         cycles++;
      end
      if (!RRdy) begin
         $display("%0t: test %0d timed out waiting for the first fetch", $time, testNum);
         errors++;
      end else begin
         checkHalt(1'b0, 0, Halt, fetchCount);
         checkStore('0, '0, RAddr, RWData, "first fetch");
      end

      cycles = 0;
      while (!Halt && cycles < runTimeout) begin
         @(negedge clk);
         cycles++;
      end
      if (!Halt) begin
         $display("%0t: test %0d timed out waiting for Halt", $time, testNum);
         errors++;
      end else begin
         for (int i = 0; i < quietCycles; i++) begin
            @(negedge clk);
            if (RRdy) begin
               $display("MISMATCH %0t: RRdy high after the halt opcode", $time);
               errors++;
            end
         end
      end
      checkHalt(1'b1, expCount, Halt, fetchCount);

      if (storeAddrQ.size() != storeLen) begin
         $display("MISMATCH %0t: test %0d expected %0d stores, saw %0d",
                  $time, testNum, storeLen, storeAddrQ.size());
         errors++;
      end
      for (int i = 0; i < storeLen && i < storeAddrQ.size(); i++) begin
         checkStore(golden[storePtr + 2*i], golden[storePtr + 2*i + 1],
                    storeAddrQ[i], storeDataQ[i], "store");
      end

      if (errors != errBefore) testsFailed++;
      $display("test %0d: %s, %0d errors", testNum,
               (errors == errBefore) ? "ok" : "failed", errors - errBefore);
   endtask

   initial begin
      rstn        = 1'b0;
      LEn         = 1'b0;
      errors      = 0;
      testsRun    = 0;
      testsFailed = 0;
      fetchCount  = 0;
      for (int i = 0; i < goldenSize; i++) golden[i] = '0;
      $readmemh("verification/lanzones_golden.txt", golden);
      gPtr = 0;
      while (golden[gPtr] != '0 && testsRun < maxTests) begin
         testsRun++;
         runTest(testsRun);
      end
      if (testsRun == 0) begin
         $display("no tests found in the golden file");
         errors++;
      end
      $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: logic/lanzonesCore.sv
`timescale 1ns/1ps

module lanzonesCore import isaPkg::*, memBusPkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  logic     LEn,
   input  logic     RVld,
   input  memWord_t RData,
   output logic     RRdy,
   output logic     RWEn,
   output logic     Halt,
   output memAddr_t RAddr,
   output memWord_t RWData
);

   instr_t   instrWord;
   logic     instrValid;
   op_t      op;
   regIdx_t  rd;
   imm_t     imm;
   memWord_t rs1Data;
   memWord_t rs2Data;
   op_t      memOp;
   memAddr_t memAddr;
   memWord_t storeData;
   logic     haltReq;
   logic     wrEn;
   regIdx_t  wrIdx;
   memWord_t wrData;
   logic     loadDone;
   memWord_t loadData;

   fetchSequencer u_seq (
      .clk(clk), .rstn(rstn), .LEn(LEn), .RVld(RVld), .RData(RData),
      .memOp(memOp), .memAddr(memAddr), .storeData(storeData), .haltReq(haltReq),
      .RRdy(RRdy), .RWEn(RWEn), .Halt(Halt), .RAddr(RAddr), .RWData(RWData),
      .instrWord(instrWord), .instrValid(instrValid),
      .loadDone(loadDone), .loadData(loadData)
   );

   instrDecoder u_dec (
      .instrWord(instrWord), .instrValid(instrValid),
      .op(op), .rd(rd), .imm(imm)
   );

   registerFile u_regs (
      .clk(clk), .rstn(rstn), .instrWord(instrWord),
      .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
      .rs1Data(rs1Data), .rs2Data(rs2Data)
   );

   executeUnit u_exe (
      .clk(clk), .rstn(rstn), .op(op), .rd(rd), .imm(imm),
      .rs1Data(rs1Data), .rs2Data(rs2Data), .loadDone(loadDone), .loadData(loadData),
      .memOp(memOp), .memAddr(memAddr), .storeData(storeData), .haltReq(haltReq),
      .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData)
   );

endmodule

// File: logic/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import isaPkg::*, memBusPkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  op_t      op,
   input  regIdx_t  rd,
   input  imm_t     imm,
   input  memWord_t rs1Data,
   input  memWord_t rs2Data,
   input  logic     loadDone,
   input  memWord_t loadData,
   output op_t      memOp,
   output memAddr_t memAddr,
   output memWord_t storeData,
   output logic     haltReq,
   output logic     wrEn,
   output regIdx_t  wrIdx,
   output memWord_t wrData
);

   memWord_t aluResult;
   regIdx_t  loadIdx;
   logic     loadPending;
   logic     aluWrite;
   logic     loadWrite;

   always_comb begin
      case (op)
         opLui:   aluResult = imm;
         opSub:   aluResult = rs1Data - rs2Data;
         default: aluResult = rs1Data + rs2Data;   // wraps mod 2^32
      endcase
   end

   assign memOp     = (op == opStore || op == opLoad) ? op : opNone;
   assign memAddr   = rs1Data + imm;
   assign storeData = rs2Data;
   assign haltReq   = (op == opHalt);

   // load destination held across the memory access
   always_ff @(posedge clk) begin
      if (!rstn) begin
         loadPending <= 1'b0;
         loadIdx     <= '0;
      end else if (op == opLoad) begin
         loadPending <= 1'b1;
         loadIdx     <= rd;
      end else if (loadDone) begin
         loadPending <= 1'b0;
      end
   end

   assign aluWrite  = (op == opLui) || (op == opAdd) || (op == opSub);
   assign loadWrite = loadDone && loadPending;

   // single write port shared by ALU results and loads
   assign wrEn   = aluWrite || loadWrite;
   assign wrIdx  = loadWrite ? loadIdx : rd;
   assign wrData = loadWrite ? loadData : aluResult;

   loadWbAlone: assert property (@(posedge clk) disable iff (!rstn)
      loadDone |-> loadPending && !aluWrite);

endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ps

module registerFile import isaPkg::*, memBusPkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  instr_t   instrWord,
   input  logic     wrEn,
   input  regIdx_t  wrIdx,
   input  memWord_t wrData,
   output memWord_t rs1Data,
   output memWord_t rs2Data
);

   memWord_t regs [numRegs];
   regIdx_t  rs1Idx;
   regIdx_t  rs2Idx;

   assign rs1Idx = instrWord[19:15];
   assign rs2Idx = instrWord[24:20];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrIdx != '0) begin   // x0 never written
         regs[wrIdx] <= wrData;
      end
   end

   // asynchronous reads
   assign rs1Data = regs[rs1Idx];
   assign rs2Data = regs[rs2Idx];

   // x0 reads zero after every edge
   zeroRegStays: assert property (@(posedge clk) disable iff (!rstn)
      regs[0] == '0);

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import isaPkg::*; (
   input  instr_t  instrWord,
   input  logic    instrValid,
   output op_t     op,
   output regIdx_t rd,
   output imm_t    imm
);

   logic [opcodeWidth-1:0] opcode;
   logic [funct7Width-1:0] funct7;
   regIdx_t rdField;
   imm_t    immU;
   imm_t    immI;
   imm_t    immS;

   assign opcode  = instrWord[6:0];
   assign rdField = instrWord[11:7];
   assign funct7  = instrWord[31:25];

   // immediate formats
   assign immU = {instrWord[31:12], 12'b0};
   assign immI = {{20{instrWord[31]}}, instrWord[31:20]};
   assign immS = {{20{instrWord[31]}}, instrWord[31:25], instrWord[11:7]};

   always_comb begin
      op  = opNone;
      rd  = '0;
      imm = '0;
      if (instrValid) begin
         case (opcode)
            opcodeLui: begin
               op  = opLui;
               rd  = rdField;
               imm = immU;
            end
            opcodeOp: begin
               rd = rdField;
               case (funct7)
                  funct7Sub: op = opSub;
                  default:   op = opAdd;   // unknown funct7 acts as ADD
               endcase
            end
            opcodeStore: begin
               op  = opStore;
               imm = immS;
            end
            opcodeLoad: begin
               op  = opLoad;   // every width loads a full word
               rd  = rdField;
               imm = immI;
            end
            opcodeHalt: begin
               op = opHalt;
            end
            default: begin
               op = opNone;   // unsupported opcode, no-op
            end
         endcase
      end
   end

endmodule

// File: logic/fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer import isaPkg::*, memBusPkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  logic     LEn,
   input  logic     RVld,
   input  memWord_t RData,
   input  op_t      memOp,
   input  memAddr_t memAddr,
   input  memWord_t storeData,
   input  logic     haltReq,
   output logic     RRdy,
   output logic     RWEn,
   output logic     Halt,
   output memAddr_t RAddr,
   output memWord_t RWData,
   output instr_t   instrWord,
   output logic     instrValid,
   output logic     loadDone,
   output memWord_t loadData
);

   typedef enum logic [1:0] {
      stIdle,
      stFetch,
      stExec,
      stMem
   } state_t;

   state_t   state;
   memAddr_t pc;
   instr_t   instrReg;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= stIdle;
         Halt   <= 1'b1;
         RRdy   <= 1'b0;
         RWEn   <= 1'b0;
         RAddr  <= '0;
         RWData <= '0;
         pc     <= '0;
      end else begin
         case (state)
            stIdle: begin
               if (LEn) begin   // resume from the current pc
                  Halt  <= 1'b0;
                  RRdy  <= 1'b1;
                  RAddr <= pc;
                  state <= stFetch;
               end
            end
            stFetch: begin
               if (!RRdy) begin   // re-entry after a memory access
                  RRdy  <= 1'b1;
                  RAddr <= pc;
               end else if (RVld) begin
                  RRdy  <= 1'b0;
                  pc    <= pc + 1'b1;
                  state <= stExec;
               end
            end
            stExec: begin
               if (haltReq) begin
                  Halt  <= 1'b1;
                  state <= stIdle;
               end else if (memOp == opStore) begin
                  RRdy   <= 1'b1;
                  RWEn   <= 1'b1;
                  RAddr  <= memAddr;
                  RWData <= storeData;
                  state  <= stMem;
               end else if (memOp == opLoad) begin
                  RRdy  <= 1'b1;
                  RAddr <= memAddr;
                  state <= stMem;
               end else begin
                  RRdy  <= 1'b1;   // no memory phase, fetch next
                  RAddr <= pc;
                  state <= stFetch;
               end
            end
            stMem: begin
               if (RVld) begin
                  RRdy   <= 1'b0;
                  RWEn   <= 1'b0;
                  RWData <= '0;
                  state  <= stFetch;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // instruction register
   always_ff @(posedge clk) begin
      if (state == stFetch && RRdy && RVld) begin
         instrReg <= RData;
      end
   end

   assign instrWord  = instrReg;
   assign instrValid = (state == stExec);
   assign loadDone   = (state == stMem) && !RWEn && RVld;   // read access of LW
   assign loadData   = RData;

   wenNeedsRdy: assert property (@(posedge clk) disable iff (!rstn)
      RWEn |-> RRdy);

   noReqWhileHalted: assert property (@(posedge clk) disable iff (!rstn)
      Halt |-> !RRdy);

   // a request waits unchanged for its strobe
   reqHeld: assert property (@(posedge clk) disable iff (!rstn)
      RRdy && !RVld |=> RRdy && $stable(RAddr) && $stable(RWEn) && $stable(RWData));

endmodule

// File: logic/memBusPkg.sv
package memBusPkg;

   localparam int addrWidth = 32;
   localparam int dataWidth = 32;

   // addresses count words, not bytes
   typedef logic [addrWidth-1:0] memAddr_t;
   typedef logic [dataWidth-1:0] memWord_t;

endpackage

// File: logic/isaPkg.sv
package isaPkg;

   // instruction field widths
   localparam int instrWidth  = 32;
   localparam int opcodeWidth = 7;
   localparam int regIdxWidth = 5;
   localparam int funct3Width = 3;
   localparam int funct7Width = 7;

   localparam int numRegs = 32;

   typedef logic [instrWidth-1:0]  instr_t;
   typedef logic [regIdxWidth-1:0] regIdx_t;
   typedef logic [instrWidth-1:0]  imm_t;   // already extended to full width

   localparam logic [opcodeWidth-1:0] opcodeLui   = 7'b0110111;
   localparam logic [opcodeWidth-1:0] opcodeOp    = 7'b0110011;
   localparam logic [opcodeWidth-1:0] opcodeStore = 7'b0100011;
   localparam logic [opcodeWidth-1:0] opcodeLoad  = 7'b0000011;
   localparam logic [opcodeWidth-1:0] opcodeHalt  = 7'b1111111;

   localparam logic [funct7Width-1:0] funct7Sub  = 7'b0100000;
   localparam logic [funct3Width-1:0] funct3Word = 3'b010;

   // one decoded operation per instruction
   typedef enum logic [2:0] {
      opNone,
      opLui,
      opAdd,
      opSub,
      opStore,
      opLoad,
      opHalt
   } op_t;

endpackage
